// ==== design/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache import mem_pkg::*; (
  input  logic   clk_in,
  input  logic   rst_in,
  input  logic   fetch_valid,
  input  addr_t  fetch_addr,
  input  logic   fill_ready,
  input  line_t  fill_line,
  output logic   fetch_ready,
  output word_t  fetch_inst,
  output logic   fill_valid,
  output addr_t  fill_addr
);

  localparam int TAG_LSB = LINE_OFFSET_BITS + ICACHE_INDEX_BITS;

  logic [31:TAG_LSB]      tag_q [ICACHE_LINES];
  line_t                  data_q [ICACHE_LINES];
  logic [ICACHE_LINES-1:0] valid_q;

  logic                         miss_q;
  logic [ICACHE_INDEX_BITS-1:0] index;
  logic [LINE_OFFSET_BITS-3:0]  word_sel;
  logic                         hit;
  logic                         lookup;
  logic                         fill_done;

  function automatic word_t pick_word(input line_t line, input logic [LINE_OFFSET_BITS-3:0] sel);
    return line[32*sel +: 32];
  endfunction

  assign index    = fetch_addr[TAG_LSB-1:LINE_OFFSET_BITS];
  assign word_sel = fetch_addr[LINE_OFFSET_BITS-1:2];
  assign hit      = valid_q[index] && tag_q[index] == fetch_addr[31:TAG_LSB];

  // fetch_valid is still up in the ready cycle, skip it there
  assign lookup    = fetch_valid && !fetch_ready && !miss_q;
  assign fill_done = miss_q && fill_ready;

  assign fill_valid = miss_q;
  assign fill_addr  = {fetch_addr[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_q     <= '0;
      miss_q      <= 1'b0;
      fetch_ready <= 1'b0;
    end else begin
      fetch_ready <= 1'b0;
      if (fill_done) begin
        valid_q[index] <= 1'b1;
        miss_q         <= 1'b0;
        fetch_ready    <= 1'b1;
      end else if (lookup) begin
        if (hit) begin
          fetch_ready <= 1'b1;
        end else begin
          miss_q <= 1'b1;
        end
      end
    end
  end

  // line storage and the returned word
  always_ff @(posedge clk_in) begin
    if (fill_done) begin
      tag_q[index]  <= fetch_addr[31:TAG_LSB];
      data_q[index] <= fill_line;
      fetch_inst    <= pick_word(fill_line, word_sel);
    end else if (lookup && hit) begin
      fetch_inst <= pick_word(data_q[index], word_sel);
    end
  end

  a_ready_needs_fetch: assert property (@(posedge clk_in) disable iff (rst_in)
    fetch_ready |-> fetch_valid);

endmodule

`default_nettype wire

// ==== design/line_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_sequencer import mem_pkg::*; (
  input  logic   clk_in,
  input  logic   rst_in,
  input  logic   rdy_in,
  input  logic   io_buffer_full,
  input  logic   start,
  input  logic   start_write,
  input  addr_t  start_addr,
  input  logic   start_len_line,
  input  line_t  start_wline,
  input  byte_t  mem_din,
  output addr_t  mem_a,
  output byte_t  mem_dout,
  output logic   mem_wr,
  output logic   done,
  output line_t  done_line,
  output byte_t  done_byte
);

  seq_state_t state;

  logic [LINE_OFFSET_BITS:0] cnt_q;
  logic [LINE_OFFSET_BITS:0] cnt_cur;
  logic [LINE_OFFSET_BITS:0] cnt_next;
  logic [LINE_OFFSET_BITS:0] cur_len;
  logic  pend_q;
  logic  in_idle;
  logic  active;
  logic  io_stall;
  logic  issue_ok;
  logic  cur_write;
  logic  cur_line;
  addr_t cur_addr;

  // command registers
  addr_t base_q;
  logic  write_q;
  logic  line_q;
  line_t wline_q;
  line_t rline_q;
  byte_t byte_q;

  // first byte goes out in the start cycle itself
  assign in_idle   = state == SEQ_IDLE;
  assign cur_addr  = in_idle ? start_addr : base_q;
  assign cur_write = in_idle ? start_write : write_q;
  assign cur_line  = in_idle ? start_len_line : line_q;
  assign cur_len   = cur_line ? (LINE_OFFSET_BITS+1)'(LINE_BYTES) : (LINE_OFFSET_BITS+1)'(1);
  assign cnt_cur   = in_idle ? '0 : cnt_q;

  assign active   = in_idle ? start : (state == SEQ_RUN && cnt_cur < cur_len);
  // uart side can only take a write when its buffer has room
  assign io_stall = cur_write && is_io_addr(cur_addr) && io_buffer_full;
  assign issue_ok = active && rdy_in && !io_stall;
  assign cnt_next = cnt_cur + (LINE_OFFSET_BITS+1)'(issue_ok);

  assign mem_a    = cur_addr + addr_t'(cnt_cur);
  assign mem_dout = in_idle ? start_wline[7:0] : wline_q[7:0];
  assign mem_wr   = issue_ok && cur_write;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state  <= SEQ_IDLE;
      cnt_q  <= '0;
      pend_q <= 1'b0;
    end else begin
      // read data shows up one cycle after its address
      pend_q <= issue_ok && !cur_write;
      case (state)
        SEQ_IDLE: begin
          if (start && rdy_in) begin
            cnt_q <= cnt_next;
            if (cur_write && cnt_next == cur_len) begin
              state <= SEQ_DONE;
            end else begin
              state <= SEQ_RUN;
            end
          end
        end
        SEQ_RUN: begin
          cnt_q <= cnt_next;
          if (cur_write && cnt_next == cur_len) begin
            state <= SEQ_DONE;
          end else if (!cur_write && cnt_cur == cur_len && pend_q) begin
            // last byte lands this cycle
            state <= SEQ_DONE;
          end
        end
        SEQ_DONE: begin
          if (rdy_in) begin
            state <= SEQ_IDLE;
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (in_idle && start && rdy_in) begin
      base_q  <= start_addr;
      write_q <= start_write;
      line_q  <= start_len_line;
      wline_q <= issue_ok ? (start_wline >> 8) : start_wline;
    end else if (issue_ok && cur_write) begin
      wline_q <= wline_q >> 8;
    end
    // bytes shift in from the top so byte 0 ends at the bottom
    if (pend_q) begin
      rline_q <= {mem_din, rline_q[LINE_BYTES*8-1:8]};
      byte_q  <= mem_din;
    end
  end

  assign done      = state == SEQ_DONE && rdy_in;
  assign done_line = rline_q;
  assign done_byte = byte_q;

  a_no_wr_paused: assert property (@(posedge clk_in) disable iff (rst_in)
    !rdy_in |-> !mem_wr);

  a_no_wr_io_full: assert property (@(posedge clk_in) disable iff (rst_in)
    (mem_wr && is_io_addr(mem_a)) |-> !io_buffer_full);

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import mem_pkg::*; (
  input  logic   clk_in,
  input  logic   rst_in,
  input  logic   rdy_in,
  input  logic   io_valid,
  input  logic   io_write,
  input  addr_t  io_addr,
  input  byte_t  io_wbyte,
  input  logic   data_valid,
  input  logic   data_write,
  input  addr_t  data_addr,
  input  line_t  data_wline,
  input  logic   fill_valid,
  input  addr_t  fill_addr,
  input  logic   done,
  input  line_t  done_line,
  input  byte_t  done_byte,
  output logic   start,
  output logic   start_write,
  output addr_t  start_addr,
  output logic   start_len_line,
  output line_t  start_wline,
  output logic   io_ready,
  output byte_t  io_rbyte,
  output logic   data_ready,
  output line_t  data_rline,
  output logic   fill_ready,
  output line_t  fill_line
);

  grant_t grant;
  grant_t winner;
  byte_t  io_rbyte_q;
  line_t  data_rline_q;

  // fixed priority, io first
  always_comb begin
    if (io_valid) begin
      winner = GRANT_IO;
    end else if (data_valid) begin
      winner = GRANT_DATA;
    end else if (fill_valid) begin
      winner = GRANT_FETCH;
    end else begin
      winner = GRANT_NONE;
    end
  end

  // start stays up until a cycle with rdy_in high takes it
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      grant <= GRANT_NONE;
      start <= 1'b0;
    end else if (rdy_in) begin
      start <= 1'b0;
      if (grant == GRANT_NONE) begin
        grant <= winner;
        start <= winner != GRANT_NONE;
      end else if (done) begin
        grant <= GRANT_NONE;
      end
    end
  end

  // operands of the winner become the start command
  always_ff @(posedge clk_in) begin
    if (rdy_in && grant == GRANT_NONE) begin
      case (winner)
        GRANT_IO: begin
          start_write    <= io_write;
          start_addr     <= io_addr;
          start_len_line <= 1'b0;
          start_wline    <= line_t'(io_wbyte);
        end
        GRANT_DATA: begin
          start_write    <= data_write;
          start_addr     <= data_addr;
          start_len_line <= 1'b1;
          start_wline    <= data_wline;
        end
        GRANT_FETCH: begin
          start_write    <= 1'b0;
          start_addr     <= fill_addr;
          start_len_line <= 1'b1;
          start_wline    <= data_wline;
        end
        default: begin
        end
      endcase
    end
  end

  assign io_ready   = done && grant == GRANT_IO;
  assign data_ready = done && grant == GRANT_DATA;
  assign fill_ready = done && grant == GRANT_FETCH;

  // results are held per port until that port completes again
  always_ff @(posedge clk_in) begin
    if (io_ready) begin
      io_rbyte_q <= done_byte;
    end
    if (data_ready) begin
      data_rline_q <= done_line;
    end
  end

  assign io_rbyte   = io_ready ? done_byte : io_rbyte_q;
  assign data_rline = data_ready ? done_line : data_rline_q;
  // icache takes the line in the ready cycle only
  assign fill_line  = done_line;

  a_done_has_owner: assert property (@(posedge clk_in) disable iff (rst_in)
    done |-> grant != GRANT_NONE);

endmodule

`default_nettype wire

// ==== design/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  // line geometry
  localparam int LINE_BYTES = 16;
  localparam int LINE_OFFSET_BITS = 4;

  // direct-mapped icache
  localparam int ICACHE_LINES = 8;
  localparam int ICACHE_INDEX_BITS = 3;

  // address bits 17:16 of the io window
  localparam logic [1:0] IO_REGION_TAG = 2'b11;

  typedef logic [31:0] addr_t;
  typedef logic [7:0] byte_t;
  typedef logic [31:0] word_t;
  typedef logic [LINE_BYTES*8-1:0] line_t;

  // current owner of the ram bus
  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_IO,
    GRANT_DATA,
    GRANT_FETCH
  } grant_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_DONE
  } seq_state_t;

  function automatic logic is_io_addr(input addr_t addr);
    return addr[17:16] == IO_REGION_TAG;
  endfunction

endpackage

`default_nettype wire

// ==== design/mem_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_system import mem_pkg::*; (
  input  logic   clk_in,
  input  logic   rst_in,
  input  logic   rdy_in,
  input  byte_t  mem_din,
  output byte_t  mem_dout,
  output addr_t  mem_a,
  output logic   mem_wr,
  input  logic   io_buffer_full,
  input  logic   fetch_valid,
  input  addr_t  fetch_addr,
  output logic   fetch_ready,
  output word_t  fetch_inst,
  input  logic   data_valid,
  input  logic   data_write,
  input  addr_t  data_addr,
  input  line_t  data_wline,
  output logic   data_ready,
  output line_t  data_rline,
  input  logic   io_valid,
  input  logic   io_write,
  input  addr_t  io_addr,
  input  byte_t  io_wbyte,
  output logic   io_ready,
  output byte_t  io_rbyte
);

  // icache line fills
  logic  fill_valid;
  addr_t fill_addr;
  logic  fill_ready;
  line_t fill_line;

  // arbiter to sequencer
  logic  start;
  logic  start_write;
  addr_t start_addr;
  logic  start_len_line;
  line_t start_wline;
  logic  done;
  line_t done_line;
  byte_t done_byte;

  icache u_icache (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .fetch_valid (fetch_valid),
    .fetch_addr  (fetch_addr),
    .fill_ready  (fill_ready),
    .fill_line   (fill_line),
    .fetch_ready (fetch_ready),
    .fetch_inst  (fetch_inst),
    .fill_valid  (fill_valid),
    .fill_addr   (fill_addr)
  );

  mem_arbiter u_arbiter (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .io_valid       (io_valid),
    .io_write       (io_write),
    .io_addr        (io_addr),
    .io_wbyte       (io_wbyte),
    .data_valid     (data_valid),
    .data_write     (data_write),
    .data_addr      (data_addr),
    .data_wline     (data_wline),
    .fill_valid     (fill_valid),
    .fill_addr      (fill_addr),
    .done           (done),
    .done_line      (done_line),
    .done_byte      (done_byte),
    .start          (start),
    .start_write    (start_write),
    .start_addr     (start_addr),
    .start_len_line (start_len_line),
    .start_wline    (start_wline),
    .io_ready       (io_ready),
    .io_rbyte       (io_rbyte),
    .data_ready     (data_ready),
    .data_rline     (data_rline),
    .fill_ready     (fill_ready),
    .fill_line      (fill_line)
  );

  line_sequencer u_sequencer (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .io_buffer_full (io_buffer_full),
    .start          (start),
    .start_write    (start_write),
    .start_addr     (start_addr),
    .start_len_line (start_len_line),
    .start_wline    (start_wline),
    .mem_din        (mem_din),
    .mem_a          (mem_a),
    .mem_dout       (mem_dout),
    .mem_wr         (mem_wr),
    .done           (done),
    .done_line      (done_line),
    .done_byte      (done_byte)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the mem_system testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_system \
  -f vlog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_mem_system)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression passed" <<< "$out"; then
  exit 0
fi
exit 1

// ==== testbench/tb_mem_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_system import mem_pkg::*; ();

  logic  clk_in;
  logic  rst_in;
  logic  rdy_in;
  byte_t mem_din;
  byte_t mem_dout;
  addr_t mem_a;
  logic  mem_wr;
  logic  io_buffer_full;
  logic  fetch_valid;
  addr_t fetch_addr;
  logic  fetch_ready;
  word_t fetch_inst;
  logic  data_valid;
  logic  data_write;
  addr_t data_addr;
  line_t data_wline;
  logic  data_ready;
  line_t data_rline;
  logic  io_valid;
  logic  io_write;
  addr_t io_addr;
  byte_t io_wbyte;
  logic  io_ready;
  byte_t io_rbyte;

  byte_t in_byte;
  int    log_count;
  byte_t last_out;

  int    errors = 0;
  int    timeouts = 0;
  int    fetch_cnt;
  int    data_cnt;
  int    io_cnt;
  int    fetch_base;
  int    data_base;
  int    io_base;
  logic  rdy_random;
  logic  race_on;
  logic  expect_hit;
  word_t exp_inst;
  line_t exp_line;
  byte_t exp_out;
  int    exp_log;
  line_t line_a;
  line_t line_b;

  mem_system DUT (.*);

  tb_ram_model ram (.*);

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  // completions, counted where the ready pulse is sampled
  always @(posedge clk_in) begin
    if (rst_in) begin
      fetch_cnt <= 0;
      data_cnt  <= 0;
      io_cnt    <= 0;
    end else begin
      fetch_cnt <= fetch_cnt + int'(fetch_ready);
      data_cnt  <= data_cnt + int'(data_ready);
      io_cnt    <= io_cnt + int'(io_ready);
    end
  end

  // bus pause about one cycle in four
  always @(negedge clk_in) begin
    if (rdy_random) begin
      rdy_in = ($urandom % 4) != 0;
    end else begin
      rdy_in = 1'b1;
    end
  end

  function automatic byte_t pattern_byte(input addr_t a);
    return a[7:0] ^ a[15:8] ^ {a[16], 7'b0};
  endfunction

  function automatic logic line_in_ram(input addr_t a, input line_t l);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < LINE_BYTES; i++) begin
      if (ram.mem[a[16:0] + 17'(i)] != l[8*i +: 8]) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  task automatic log_error(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic fetch_word(input addr_t a, input logic hit);
    exp_inst = {pattern_byte(a + 3), pattern_byte(a + 2),
                pattern_byte(a + 1), pattern_byte(a)};
    expect_hit  = hit;
    fetch_addr  = a;
    fetch_valid = 1'b1;
  endtask

  task automatic request_line(input logic wr, input addr_t a, input line_t l);
    exp_line   = l;
    data_write = wr;
    data_addr  = a;
    data_wline = l;
    data_valid = 1'b1;
  endtask

  task automatic request_byte(input logic wr, input addr_t a, input byte_t b);
    if (wr) begin
      exp_out = b;
      exp_log++;
    end
    io_write = wr;
    io_addr  = a;
    io_wbyte = b;
    io_valid = 1'b1;
  endtask

  // drops each valid the cycle after its ready
  task automatic wait_for_ready(input logic want_fetch, input logic want_data,
                                input logic want_io);
    int   f0;
    int   d0;
    int   i0;
    int   n;
    logic f_ok;
    logic d_ok;
    logic i_ok;
    f0 = fetch_cnt;
    d0 = data_cnt;
    i0 = io_cnt;
    f_ok = !want_fetch;
    d_ok = !want_data;
    i_ok = !want_io;
    n = 0;
    while (!(f_ok && d_ok && i_ok) && n < 400) begin
      @(negedge clk_in);
      n++;
      if (!f_ok && fetch_cnt != f0) begin
        f_ok = 1'b1;
        fetch_valid = 1'b0;
      end
      if (!d_ok && data_cnt != d0) begin
        d_ok = 1'b1;
        data_valid = 1'b0;
      end
      if (!i_ok && io_cnt != i0) begin
        i_ok = 1'b1;
        io_valid = 1'b0;
      end
    end
    if (!(f_ok && d_ok && i_ok)) begin
      timeouts++;
      $display("timeout after %0d cycles: a request never got its ready pulse", n);
      fetch_valid = 1'b0;
      data_valid  = 1'b0;
      io_valid    = 1'b0;
    end
  endtask

  task automatic run_basic(input addr_t fetch_at, input addr_t line_at, input line_t wl,
                           input byte_t out_byte);
    // cold fetch misses, the repeat hits
    @(negedge clk_in);
    fetch_word(fetch_at, 1'b0);
    wait_for_ready(1'b1, 1'b0, 1'b0);
    @(negedge clk_in);
    fetch_word(fetch_at, 1'b1);
    wait_for_ready(1'b1, 1'b0, 1'b0);
    @(negedge clk_in);
    request_line(1'b1, line_at, wl);
    wait_for_ready(1'b0, 1'b1, 1'b0);
    @(negedge clk_in);
    request_line(1'b0, line_at, wl);
    wait_for_ready(1'b0, 1'b1, 1'b0);
    // uart buffer full while the write is pending
    @(negedge clk_in);
    io_buffer_full = 1'b1;
    request_byte(1'b1, 32'h0003_0000, out_byte);
    repeat (8) @(negedge clk_in);
    io_buffer_full = 1'b0;
    wait_for_ready(1'b0, 1'b0, 1'b1);
    @(negedge clk_in);
    request_byte(1'b0, 32'h0003_0000, 8'h00);
    wait_for_ready(1'b0, 1'b0, 1'b1);
  endtask

  a_reset_quiet: assert property (@(posedge clk_in)
    $past(rst_in) |-> !(fetch_ready || data_ready || io_ready || mem_wr))
    else log_error("ready or mem_wr high in or right after reset");
  a_fetch_value: assert property (@(posedge clk_in) disable iff (rst_in)
    fetch_ready |-> fetch_inst == exp_inst)
    else log_error("fetch_inst differs from the preloaded word");
  a_hit_latency: assert property (@(posedge clk_in) disable iff (rst_in)
    (expect_hit && $rose(fetch_valid)) |=> fetch_ready)
    else log_error("repeat fetch took more than one cycle");
  a_miss_latency: assert property (@(posedge clk_in) disable iff (rst_in)
    (!expect_hit && $rose(fetch_valid)) |=> !fetch_ready)
    else log_error("cold fetch answered as a hit");
  a_data_value: assert property (@(posedge clk_in) disable iff (rst_in)
    (data_ready && !data_write) |-> data_rline == exp_line)
    else log_error("data line read back wrong");
  a_data_in_ram: assert property (@(posedge clk_in) disable iff (rst_in)
    (data_ready && data_write) |-> line_in_ram(data_addr, data_wline))
    else log_error("ram bytes differ from the written line");
  a_io_read: assert property (@(posedge clk_in) disable iff (rst_in)
    (io_ready && !io_write) |-> io_rbyte == in_byte)
    else log_error("io read returned the wrong byte");
  a_io_log: assert property (@(posedge clk_in) disable iff (rst_in)
    (io_ready && io_write) |-> (log_count == exp_log && last_out == exp_out))
    else log_error("io write missing from the output log");
  a_io_hold: assert property (@(posedge clk_in) disable iff (rst_in)
    (mem_wr && mem_a[17:16] == 2'b11) |-> !io_buffer_full)
    else log_error("io write issued while the buffer was full");
  a_paused_no_wr: assert property (@(posedge clk_in) disable iff (rst_in)
    !rdy_in |-> !mem_wr)
    else log_error("mem_wr high in a paused cycle");
  a_race_io_first: assert property (@(posedge clk_in) disable iff (rst_in)
    (race_on && io_ready) |-> (data_cnt == data_base && fetch_cnt == fetch_base))
    else log_error("io finished after another requester");
  a_race_data_second: assert property (@(posedge clk_in) disable iff (rst_in)
    (race_on && data_ready) |-> (io_cnt != io_base && fetch_cnt == fetch_base))
    else log_error("data finished out of order");
  a_race_fetch_last: assert property (@(posedge clk_in) disable iff (rst_in)
    (race_on && fetch_ready) |-> data_cnt != data_base)
    else log_error("fetch finished before data");

  initial begin
    void'($urandom(13350));
    rst_in = 1'b1;
    rdy_in = 1'b1;
    io_buffer_full = 1'b0;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    data_valid  = 1'b0;
    data_write  = 1'b0;
    data_addr   = '0;
    data_wline  = '0;
    io_valid = 1'b0;
    io_write = 1'b0;
    io_addr  = '0;
    io_wbyte = '0;
    in_byte  = 8'h5a;
    rdy_random = 1'b0;
    race_on    = 1'b0;
    expect_hit = 1'b0;
    exp_inst = '0;
    exp_line = '0;
    exp_out  = '0;
    exp_log  = 0;
    fetch_base = 0;
    data_base  = 0;
    io_base    = 0;
    repeat (16) @(negedge clk_in);
    rst_in = 1'b0;

    line_a = {$urandom, $urandom, $urandom, $urandom};
    run_basic(32'h0000_0124, 32'h0000_2000, line_a, 8'ha5);

    // all three requesters in one cycle
    @(negedge clk_in);
    io_base    = io_cnt;
    data_base  = data_cnt;
    fetch_base = fetch_cnt;
    race_on    = 1'b1;
    request_byte(1'b0, 32'h0003_0000, 8'h00);
    request_line(1'b0, 32'h0000_2000, line_a);
    fetch_word(32'h0000_0a7c, 1'b0);
    wait_for_ready(1'b1, 1'b1, 1'b1);
    race_on = 1'b0;

    rdy_random = 1'b1;
    line_b = {$urandom, $urandom, $urandom, $urandom};
    run_basic(32'h0000_1568, 32'h0000_4a30, line_b, byte_t'($urandom));
    rdy_random = 1'b0;
    repeat (4) @(negedge clk_in);

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_ram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// 128 KB byte ram on the 8-bit bus with an io window at bits 17:16 == 11
module tb_ram_model import mem_pkg::*; (
  input  logic  clk_in,
  input  addr_t mem_a,
  input  byte_t mem_dout,
  input  logic  mem_wr,
  input  byte_t in_byte,
  output byte_t mem_din,
  output int    log_count,
  output byte_t last_out
);

  byte_t mem [0:131071];
  logic  io_hit;

  // low address byte xor the next one with bit 16 folded into the top bit
  initial begin
    for (int i = 0; i < 131072; i++) begin
      mem[i] = i[7:0] ^ i[15:8] ^ {i[16], 7'b0};
    end
    log_count = 0;
    last_out  = '0;
    mem_din   = '0;
  end

  assign io_hit = mem_a[17:16] == 2'b11;

  always @(posedge clk_in) begin
    if (mem_wr && io_hit) begin
      log_count <= log_count + 1;
      last_out  <= mem_dout;
    end else if (mem_wr) begin
      mem[mem_a[16:0]] <= mem_dout;
    end
    // read data one cycle after its address
    mem_din <= io_hit ? in_byte : mem[mem_a[16:0]];
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/mem_pkg.sv
design/line_sequencer.sv
design/mem_arbiter.sv
design/icache.sv
design/mem_system.sv
testbench/tb_ram_model.sv
testbench/tb_mem_system.sv
